// File: include/addSub_defines.svh
`ifndef ADDSUB_DEFINES_SVH
`define ADDSUB_DEFINES_SVH

// Operand width. Bits are numbered WORD_W down to 1.
`define WORD_W 15

// Gate delay on the adder carry and sum nets.
// Simulation only, synthesis drops it.
`define CLA_DLY 1

// Most positive and most negative signed words.
`define WORD_MAX {1'b0, {(`WORD_W-1){1'b1}}}
`define WORD_MIN {1'b1, {(`WORD_W-1){1'b0}}}

// Sign bit position.
`define WORD_MSB `WORD_W

`endif

// File: verilog/addSubPkg.sv
`default_nettype none

package addSubPkg;

  // Operation codes.
  // Bit 0 selects subtract and bit 1 selects saturation.
  typedef enum logic [1:0] {
    OP_ADD  = 2'b00, // Wrapping add.
    OP_SUB  = 2'b01, // Wrapping subtract.
    OP_ADDS = 2'b10, // Saturating add.
    OP_SUBS = 2'b11  // Saturating subtract.
  } aluOpT;

  // Result status.
  typedef struct packed {
    logic zero;
    logic negative;
    logic overflow;
  } flagsT;

  // Number of fields in flagsT.
  localparam int FLAG_W = $bits(flagsT);

endpackage : addSubPkg

`default_nettype wire

// File: verilog/addStageIf.sv
`timescale 1ns/1ps
`default_nettype none

`include "addSub_defines.svh"

// Stage one to stage two handshake.
// Data fields hold only while valid is high.
interface addStageIf;

  logic              valid; // One cycle strobe.
  logic              sat;   // Clamp on overflow.
  logic [`WORD_W:1]  opA;
  logic [`WORD_W:1]  opB;   // Inverted for subtract.
  logic              cin;

  modport prep (
    output valid, sat, opA, opB, cin
  );

  modport result (
    input valid, sat, opA, opB, cin
  );

endinterface : addStageIf

`default_nettype wire

// File: verilog/cla15.sv
`timescale 1ns/1ps
`default_nettype none

`include "addSub_defines.svh"

module cla15 (
  input  wire  [`WORD_W:1] a,
  input  wire  [`WORD_W:1] b,
  input  wire              cin,
  output logic [`WORD_W:1] sum
);

  // Bit 15 only needs its half sum.
  logic [`WORD_W-1:1] p;
  logic [`WORD_W-1:1] g;
  logic [`WORD_W:1]   ps;
  logic               gs;

  assign p  = a[`WORD_W-1:1] | b[`WORD_W-1:1];
  assign g  = a[`WORD_W-1:1] & b[`WORD_W-1:1];
  assign ps = a ^ b;
  assign gs = g[1] | (p[1] & cin); // Bit 1 generate with carry in folded.

  // First level, pairs of bits.
  logic [7:1] g1;
  logic [7:2] p1;

  assign g1[1] = g[2]  | (p[2]  & gs);
  assign g1[2] = g[4]  | (p[4]  & g[3]);
  assign g1[3] = g[6]  | (p[6]  & g[5]);
  assign g1[4] = g[8]  | (p[8]  & g[7]);
  assign g1[5] = g[10] | (p[10] & g[9]);
  assign g1[6] = g[12] | (p[12] & g[11]);
  assign g1[7] = g[14] | (p[14] & g[13]);

  assign p1[2] = p[4]  & p[3];
  assign p1[3] = p[6]  & p[5];
  assign p1[4] = p[8]  & p[7];
  assign p1[5] = p[10] & p[9];
  assign p1[6] = p[12] & p[11];
  assign p1[7] = p[14] & p[13];

  // Second level, groups of four.
  logic [3:1] g2;
  logic [3:2] p2;

  assign g2[1] = g1[2] | (p1[2] & g1[1]);
  assign g2[2] = g1[4] | (p1[4] & g1[3]);
  assign g2[3] = g1[6] | (p1[6] & g1[5]);

  assign p2[2] = p1[4] & p1[3];
  assign p2[3] = p1[6] & p1[5];

  // Third level, low eight bits.
  logic g3;

  assign g3 = g2[2] | (p2[2] & g2[1]);

  // cN is the carry out of bit N.
  logic c1, c2, c3, c4, c5, c6, c7;
  logic c8, c9, c10, c11, c12, c13, c14;
  logic t1, t2, t3;

  assign #`CLA_DLY c1  = gs;
  assign #`CLA_DLY c2  = g1[1];
  assign #`CLA_DLY c3  = g[3] | (g1[1] & p[3]);

  assign #`CLA_DLY c4  = g2[1];
  assign #`CLA_DLY c5  = g[5]  | (g2[1] & p[5]);
  assign #`CLA_DLY c6  = g1[3] | (g2[1] & p1[3]);
  assign #`CLA_DLY c7  = g[7]  | (c6 & p[7]); // Ripples off c6.

  assign #`CLA_DLY c8  = g3;
  assign #`CLA_DLY c9  = g[9]  | (g3 & p[9]);
  assign #`CLA_DLY c10 = g1[5] | (g3 & p1[5]);
  assign #`CLA_DLY t1  = g[11] | (g1[5] & p[11]);
  assign #`CLA_DLY c11 = t1 | (g3 & p[11] & p1[5]);

  assign #`CLA_DLY c12 = g2[3] | (g3 & p2[3]);
  assign #`CLA_DLY t2  = g[13] | (g2[3] & p[13]);
  assign #`CLA_DLY c13 = t2 | (g3 & p2[3] & p[13]);
  assign #`CLA_DLY t3  = g1[7] | (g2[3] & p1[7]);
  assign #`CLA_DLY c14 = t3 | (g3 & p2[3] & p1[7]);

  assign #`CLA_DLY sum[1]  = cin ^ ps[1];
  assign #`CLA_DLY sum[2]  = c1  ^ ps[2];
  assign #`CLA_DLY sum[3]  = c2  ^ ps[3];
  assign #`CLA_DLY sum[4]  = c3  ^ ps[4];
  assign #`CLA_DLY sum[5]  = c4  ^ ps[5];
  assign #`CLA_DLY sum[6]  = c5  ^ ps[6];
  assign #`CLA_DLY sum[7]  = c6  ^ ps[7];
  assign #`CLA_DLY sum[8]  = c7  ^ ps[8];
  assign #`CLA_DLY sum[9]  = c8  ^ ps[9];
  assign #`CLA_DLY sum[10] = c9  ^ ps[10];
  assign #`CLA_DLY sum[11] = c10 ^ ps[11];
  assign #`CLA_DLY sum[12] = c11 ^ ps[12];
  assign #`CLA_DLY sum[13] = c12 ^ ps[13];
  assign #`CLA_DLY sum[14] = c13 ^ ps[14];
  assign #`CLA_DLY sum[15] = c14 ^ ps[15];

endmodule : cla15

`default_nettype wire

// File: verilog/operandPrep.sv
`timescale 1ns/1ps
`default_nettype none

`include "addSub_defines.svh"

module operandPrep
  import addSubPkg::*;
(
  input  wire              clk,
  input  wire              rstN,
  input  wire              inValid,
  input  wire aluOpT       op,
  input  wire [`WORD_W:1]  a,
  input  wire [`WORD_W:1]  b,
  addStageIf.prep          stage
);

  logic             isSub;
  logic             isSat;
  logic [`WORD_W:1] bCond;
  logic             cinCond;

  always_comb begin
    case (op)
      OP_ADD:  {isSub, isSat} = 2'b00;
      OP_SUB:  {isSub, isSat} = 2'b10;
      OP_ADDS: {isSub, isSat} = 2'b01;
      OP_SUBS: {isSub, isSat} = 2'b11;
      default: {isSub, isSat} = 2'b00;
    endcase
  end

  // a - b is a + ~b + 1.
  assign bCond   = isSub ? ~b : b;
  assign cinCond = isSub;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      stage.valid <= 1'b0;
    end else begin
      stage.valid <= inValid;
    end
  end

  // Payload only loads on an accepted operation.
  always_ff @(posedge clk) begin
    if (inValid) begin
      stage.opA <= a;
      stage.opB <= bCond;
      stage.cin <= cinCond;
      stage.sat <= isSat;
    end
  end

endmodule : operandPrep

`default_nettype wire

// File: verilog/resultStage.sv
`timescale 1ns/1ps
`default_nettype none

`include "addSub_defines.svh"

module resultStage
  import addSubPkg::*;
(
  input  wire              clk,
  input  wire              rstN,
  addStageIf.result        stage,
  output logic             outValid,
  output logic [`WORD_W:1] result,
  output flagsT            flags
);

  logic [`WORD_W:1] rawSum;
  logic [`WORD_W:1] satValue;
  logic [`WORD_W:1] finalSum;
  logic             sameSign;
  logic             ovf;
  flagsT            flagsNext;

  cla15 u_cla15 (
    .a   (stage.opA),
    .b   (stage.opB),
    .cin (stage.cin),
    .sum (rawSum)
  );

  // Operands share a sign but the sum does not.
  assign sameSign = stage.opA[`WORD_MSB] == stage.opB[`WORD_MSB];
  assign ovf      = sameSign && (rawSum[`WORD_MSB] != stage.opA[`WORD_MSB]);

  // Clamp toward the sign of a.
  assign satValue = stage.opA[`WORD_MSB] ? `WORD_MIN : `WORD_MAX;

  always_comb begin
    if (stage.sat && ovf) begin
      finalSum = satValue;
    end else begin
      finalSum = rawSum;
    end
  end

  always_comb begin
    flagsNext.zero     = finalSum == '0;
    flagsNext.negative = finalSum[`WORD_MSB];
    flagsNext.overflow = ovf; // Raw overflow, even when clamped.
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      outValid <= 1'b0;
    end else begin
      outValid <= stage.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (stage.valid) begin
      result <= finalSum;
      flags  <= flagsNext;
    end
  end

endmodule : resultStage

`default_nettype wire

// File: verilog/addSubUnit.sv
`timescale 1ns/1ps
`default_nettype none

`include "addSub_defines.svh"

// Two stage signed add and subtract.
// Result appears two cycles after inValid.
module addSubUnit
  import addSubPkg::*;
(
  input  wire              clk,
  input  wire              rstN,
  input  wire              inValid,
  input  wire aluOpT       op,
  input  wire [`WORD_W:1]  a,
  input  wire [`WORD_W:1]  b,
  output logic             outValid,
  output logic [`WORD_W:1] result,
  output logic             zero,
  output logic             negative,
  output logic             overflow
);

  flagsT flags;

  addStageIf stageIf ();

  operandPrep u_operandPrep (
    .clk     (clk),
    .rstN    (rstN),
    .inValid (inValid),
    .op      (op),
    .a       (a),
    .b       (b),
    .stage   (stageIf.prep)
  );

  resultStage u_resultStage (
    .clk      (clk),
    .rstN     (rstN),
    .stage    (stageIf.result),
    .outValid (outValid),
    .result   (result),
    .flags    (flags)
  );

  // Flags leave as separate ports.
  assign zero     = flags.zero;
  assign negative = flags.negative;
  assign overflow = flags.overflow;

endmodule : addSubUnit

`default_nettype wire

// File: tests/addSubUnitTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "addSub_defines.svh"

module addSubUnitTb
  import addSubPkg::*;
();

  localparam int RESET_CYCLES = 3;
  localparam int NUM_RANDOM   = 200;
  localparam int RAND_SEED    = 43735;
  localparam int DRIVE_DLY    = 1;
  localparam int LATENCY      = 2;
  localparam int MAX_POS      = (1 << (`WORD_W - 1)) - 1;
  localparam int MAX_NEG      = -(1 << (`WORD_W - 1));

  localparam logic [`WORD_W:1] SAT_POS = 15'h3FFF;
  localparam logic [`WORD_W:1] SAT_NEG = 15'h4000;

  typedef struct packed {
    aluOpT            op;
    logic [`WORD_W:1] a;
    logic [`WORD_W:1] b;
    logic [`WORD_W:1] res;
    logic             zero;
    logic             neg;
    logic             ovf;
  } vecT;

  typedef struct packed {
    logic [`WORD_W:1] res;
    logic             zero;
    logic             neg;
    logic             ovf;
    int               due; // Cycle in which outValid must be high.
  } expT;

  logic             clk;
  logic             rstN;
  logic             inValid;
  aluOpT            op;
  logic [`WORD_W:1] a;
  logic [`WORD_W:1] b;
  logic             outValid;
  logic [`WORD_W:1] result;
  logic             zero;
  logic             negative;
  logic             overflow;

  vecT  vecTable[$];
  expT  expQ[$];
  int   cycleCount = 0;
  int   timeoutLimit = 0;
  int   checkCount = 0;
  int   errorCount = 0;
  logic checking = 1'b0;

  addSubUnit u_addSubUnit (
    .clk      (clk),
    .rstN     (rstN),
    .inValid  (inValid),
    .op       (op),
    .a        (a),
    .b        (b),
    .outValid (outValid),
    .result   (result),
    .zero     (zero),
    .negative (negative),
    .overflow (overflow)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk; // 8 ns period.

  always @(posedge clk) begin
    cycleCount = cycleCount + 1;
    if (cycleCount > timeoutLimit) begin
      $display("Timeout after %0d cycles, %0d results still pending", cycleCount, expQ.size());
      $display("CHECKS FAILED");
      $finish;
    end
  end

  function automatic int toSigned(input logic [`WORD_W:1] x);
    return x[`WORD_MSB] ? int'(x) - (1 << `WORD_W) : int'(x);
  endfunction

  // Reference model in plain integer arithmetic.
  function automatic vecT modelOp(input aluOpT opIn, input logic [`WORD_W:1] aIn,
                                  input logic [`WORD_W:1] bIn);
    vecT  v;
    int   sa;
    int   sb;
    int   t;
    logic isSub;
    logic isSat;
    sa    = toSigned(aIn);
    sb    = toSigned(bIn);
    isSub = (opIn == OP_SUB) || (opIn == OP_SUBS);
    isSat = (opIn == OP_ADDS) || (opIn == OP_SUBS);
    t     = isSub ? sa - sb : sa + sb;
    v.op  = opIn;
    v.a   = aIn;
    v.b   = bIn;
    v.ovf = (t > MAX_POS) || (t < MAX_NEG);
    v.res = t[`WORD_W-1:0]; // Wraps to the low word.
    if (isSat && v.ovf) begin
      v.res = aIn[`WORD_MSB] ? SAT_NEG : SAT_POS;
    end
    v.zero = (v.res == '0);
    v.neg  = v.res[`WORD_MSB];
    return v;
  endfunction

  task automatic addVec(input aluOpT opIn, input logic [`WORD_W:1] aIn,
                        input logic [`WORD_W:1] bIn, input logic [`WORD_W:1] res,
                        input logic zf, input logic nf, input logic vf);
    vecT v;
    v = '{op: opIn, a: aIn, b: bIn, res: res, zero: zf, neg: nf, ovf: vf};
    vecTable.push_back(v);
  endtask

  task automatic loadTable;
    addVec(OP_ADD,  15'h0005, 15'h0003, 15'h0008, 0, 0, 0);
    addVec(OP_SUB,  15'h0005, 15'h0005, 15'h0000, 1, 0, 0); // Zero flag.
    addVec(OP_ADD,  15'h3FFF, 15'h0001, 15'h4000, 0, 1, 1); // Wraps to minimum.
    addVec(OP_SUB,  15'h4000, 15'h0001, 15'h3FFF, 0, 0, 1);
    addVec(OP_ADDS, 15'h3FFF, 15'h0001, 15'h3FFF, 0, 0, 1);
    addVec(OP_SUBS, 15'h4000, 15'h0001, 15'h4000, 0, 1, 1); // Saturated minimum.
    addVec(OP_ADD,  15'h7FFF, 15'h0001, 15'h0000, 1, 0, 0); // Full width carry.
    addVec(OP_ADD,  15'h5555, 15'h2AAA, 15'h7FFF, 0, 1, 0);
    addVec(OP_ADD,  15'h5555, 15'h2AAB, 15'h0000, 1, 0, 0);
    addVec(OP_SUB,  15'h2AAA, 15'h5555, 15'h5555, 0, 1, 1);
    addVec(OP_SUBS, 15'h2AAA, 15'h5555, 15'h3FFF, 0, 0, 1);
    addVec(OP_ADDS, 15'h0100, 15'h0200, 15'h0300, 0, 0, 0);
    addVec(OP_SUBS, 15'h0010, 15'h0020, 15'h7FF0, 0, 1, 0);
    addVec(OP_ADDS, 15'h4000, 15'h7FFF, 15'h4000, 0, 1, 1);
    addVec(OP_SUB,  15'h0000, 15'h4000, 15'h4000, 0, 1, 1);
    addVec(OP_SUBS, 15'h0000, 15'h4000, 15'h3FFF, 0, 0, 1);
    addVec(OP_ADD,  15'h1234, 15'h0DCC, 15'h2000, 0, 0, 0);
    addVec(OP_SUB,  15'h0001, 15'h0002, 15'h7FFF, 0, 1, 0);
  endtask

  task automatic stepCycle;
    @(posedge clk);
    #DRIVE_DLY;
  endtask

  task automatic issueOp(input vecT v);
    expT e;
    op      = v.op;
    a       = v.a;
    b       = v.b;
    inValid = 1'b1;
    e       = '{res: v.res, zero: v.zero, neg: v.neg, ovf: v.ovf, due: cycleCount + LATENCY};
    expQ.push_back(e);
  endtask

  task automatic drainResults;
    inValid = 1'b0;
    while (expQ.size() != 0) begin
      stepCycle();
    end
  endtask

  task automatic checkField(input string name, input logic [`WORD_W:1] got,
                            input logic [`WORD_W:1] exp);
    checkCount = checkCount + 1;
    if (got !== exp) begin
      errorCount = errorCount + 1;
      $display("MISMATCH t=%0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic reportTest(input string name, input int checks0, input int errors0);
    $display("Test %s done: %0d checks, %0d errors", name,
             checkCount - checks0, errorCount - errors0);
  endtask

  // Outputs are settled by the falling edge.
  always @(negedge clk) begin
    expT e;
    if (checking) begin
      if (outValid === 1'b1) begin
        if (expQ.size() == 0) begin
          errorCount = errorCount + 1;
          $display("Error at t=%0t: outValid high with no operation pending", $time);
        end else begin
          e = expQ.pop_front();
          checkCount = checkCount + 1;
          if (cycleCount != e.due) begin
            errorCount = errorCount + 1;
            $display("Error at t=%0t: result came in cycle %0d, expected cycle %0d",
                     $time, cycleCount, e.due);
          end
          checkField("result", result, e.res);
          checkField("zero", zero, e.zero);
          checkField("negative", negative, e.neg);
          checkField("overflow", overflow, e.ovf);
        end
      end else if (expQ.size() != 0 && expQ[0].due == cycleCount) begin
        errorCount = errorCount + 1;
        $display("Error at t=%0t: outValid missing for a result due in cycle %0d",
                 $time, cycleCount);
        void'(expQ.pop_front());
      end
    end
  end

  initial begin
    int    checks0;
    int    errors0;
    int    seedDummy;
    logic  [31:0] rndA;
    logic  [31:0] rndB;
    aluOpT rndOp;
    rstN    = 1'b0;
    inValid = 1'b0;
    op      = OP_ADD;
    a       = '0;
    b       = '0;
    seedDummy = $urandom(RAND_SEED);
    loadTable();
    timeoutLimit = RESET_CYCLES + vecTable.size() + NUM_RANDOM + 20;

    repeat (RESET_CYCLES) stepCycle();
    rstN = 1'b1;

    checks0 = checkCount;
    errors0 = errorCount;
    checkField("outValid", outValid, 1'b0);
    checking = 1'b1;
    repeat (2) stepCycle(); // Any stray outValid is caught here.
    reportTest("reset", checks0, errors0);

    // Table entries go in on consecutive cycles.
    checks0 = checkCount;
    errors0 = errorCount;
    foreach (vecTable[i]) begin
      issueOp(vecTable[i]);
      stepCycle();
    end
    drainResults();
    reportTest("directed", checks0, errors0);

    checks0 = checkCount;
    errors0 = errorCount;
    for (int i = 0; i < NUM_RANDOM; i++) begin
      rndOp = aluOpT'($urandom_range(3, 0));
      rndA  = $urandom;
      rndB  = $urandom;
      issueOp(modelOp(rndOp, rndA[`WORD_W-1:0], rndB[`WORD_W-1:0]));
      stepCycle();
    end
    drainResults();
    reportTest("random", checks0, errors0);

    $display("Summary: %0d checks, %0d errors", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule : addSubUnitTb

`default_nettype wire

// File: addSubUnit.f
+incdir+include
verilog/addSubPkg.sv
verilog/addStageIf.sv
verilog/cla15.sv
verilog/operandPrep.sv
verilog/resultStage.sv
verilog/addSubUnit.sv
tests/addSubUnitTb.sv
